// ==== include/rename_cfg.svh ====
`ifndef RENAME_CFG_SVH
`define RENAME_CFG_SVH

// Instructions renamed per cycle
`define SS_SIZE 2

// Architectural and physical register file sizes
`define NUM_GEN_REG 32
`define NUM_PHYS_REG 64

// Top physical tag, held by register 0 and never allocated
`define DUMMY_TAG (`NUM_PHYS_REG - 1)

// Branch snapshot slots
`define NUM_CHECKPOINTS 4

`endif

// ==== logic/rename_pkg.sv ====
`default_nettype none

`include "rename_cfg.svh"

package rename_pkg;

	typedef logic [$clog2(`NUM_GEN_REG)-1:0] gen_reg_t;
	typedef logic [$clog2(`NUM_PHYS_REG)-1:0] phys_tag_t;
	typedef logic [$clog2(`NUM_CHECKPOINTS)-1:0] branch_id_t;
	typedef logic [$clog2(`NUM_PHYS_REG):0] free_ptr_t; // Index plus wrap bit

	typedef struct packed {
		logic ready;
		phys_tag_t tag;
	} map_row_t;

	typedef map_row_t [`NUM_GEN_REG-1:0] map_t;

	// Power-up mapping: register i on tag i, register 0 on the dummy tag
	function automatic map_t reset_map();
		map_t rows;
		for (int r = 0; r < `NUM_GEN_REG; r++) begin
			rows[r].ready = 1'b1;
			rows[r].tag = phys_tag_t'(r);
		end
		rows[0].tag = phys_tag_t'(`DUMMY_TAG);
		return rows;
	endfunction

endpackage

`default_nettype wire

// ==== logic/rename_if.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rename_cfg.svh"

// Per-slot dispatch group between the top level, the map and the free list
interface dispatch_if import rename_pkg::*; ();
	logic [`SS_SIZE-1:0] enable; // Already gated by acceptance
	gen_reg_t [`SS_SIZE-1:0] reg_a;
	gen_reg_t [`SS_SIZE-1:0] reg_b;
	gen_reg_t [`SS_SIZE-1:0] reg_dest;
	phys_tag_t [`SS_SIZE-1:0] alloc_tag;
	logic [`SS_SIZE-1:0] available; // Bit i set when more than i tags are free
	logic [`SS_SIZE-1:0] take;

	modport renamer (input enable, reg_a, reg_b, reg_dest, alloc_tag, output take);
	modport supplier (input take, output alloc_tag, available);
	modport source (output enable, reg_a, reg_b, reg_dest, input alloc_tag, available);
endinterface

// Branch snapshot traffic
interface checkpoint_if import rename_pkg::*; ();
	logic save;
	branch_id_t save_id;
	logic restore;
	branch_id_t restore_id;
	map_t map_snapshot; // Map after this cycle's dispatch
	free_ptr_t head_snapshot;
	map_t restored_map;
	free_ptr_t restored_head;

	modport store (input save, save_id, restore_id, map_snapshot, head_snapshot,
		output restored_map, restored_head);
	modport renamer (input restore, restored_map, output map_snapshot);
	modport supplier (input restore, restored_head, output head_snapshot);
	modport control (output save, save_id, restore, restore_id);
endinterface

`default_nettype wire

// ==== logic/tag_cam.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rename_cfg.svh"

module tag_cam import rename_pkg::*; (
	input map_t rows,
	input logic [`SS_SIZE-1:0] cdb_valid,
	input phys_tag_t [`SS_SIZE-1:0] cdb_tag,
	output logic [`NUM_GEN_REG-1:0] hits
);

	logic [`SS_SIZE-1:0] match [`NUM_GEN_REG];

	// One comparator per row and bus slot
	for (genvar r = 0; r < `NUM_GEN_REG; r++) begin : g_row
		for (genvar s = 0; s < `SS_SIZE; s++) begin : g_slot
			assign match[r][s] = cdb_valid[s] && (rows[r].tag == cdb_tag[s]);
		end
		assign hits[r] = |match[r]; // Either bus slot wakes the row
	end

endmodule

`default_nettype wire

// ==== logic/map_table.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rename_cfg.svh"

module map_table import rename_pkg::*; (
	input logic clock,
	input logic reset,
	dispatch_if.renamer dispatch,
	checkpoint_if.renamer ckpt,
	input logic [`SS_SIZE-1:0] cdb_valid,
	input phys_tag_t [`SS_SIZE-1:0] cdb_tag,
	output phys_tag_t [`SS_SIZE-1:0] t1,
	output phys_tag_t [`SS_SIZE-1:0] t2,
	output phys_tag_t [`SS_SIZE-1:0] t_old,
	output logic [`SS_SIZE-1:0] t1_ready,
	output logic [`SS_SIZE-1:0] t2_ready
);

	map_t rows;
	map_t woken; // Rows after the completion bus
	map_t next_rows; // Rows after the completion bus and dispatch
	logic [`NUM_GEN_REG-1:0] hits;
	logic [`SS_SIZE-1:0] take;

	tag_cam tag_cam_i (
		.rows(rows),
		.cdb_valid(cdb_valid),
		.cdb_tag(cdb_tag),
		.hits(hits)
	);

	// Register 0 never takes a tag, so its row stays on the dummy tag
	always_comb begin
		for (int s = 0; s < `SS_SIZE; s++) begin
			take[s] = dispatch.enable[s] && (dispatch.reg_dest[s] != '0);
		end
	end

	assign dispatch.take = take;

	always_comb begin
		woken = rows;
		for (int r = 0; r < `NUM_GEN_REG; r++) begin
			if (hits[r])
				woken[r].ready = 1'b1;
		end
	end

	// Slots in program order, so a later slot sees an earlier slot's new mapping
	always_comb begin
		next_rows = woken;
		for (int s = 0; s < `SS_SIZE; s++) begin
			t1[s] = next_rows[dispatch.reg_a[s]].tag;
			t1_ready[s] = next_rows[dispatch.reg_a[s]].ready;
			t2[s] = next_rows[dispatch.reg_b[s]].tag;
			t2_ready[s] = next_rows[dispatch.reg_b[s]].ready;
			t_old[s] = next_rows[dispatch.reg_dest[s]].tag; // Freed when this slot retires
			if (take[s]) begin
				next_rows[dispatch.reg_dest[s]].ready = 1'b0;
				next_rows[dispatch.reg_dest[s]].tag = dispatch.alloc_tag[s];
			end
		end
	end

	assign ckpt.map_snapshot = next_rows;

	always_ff @(posedge clock) begin
		if (reset)
			rows <= reset_map();
		else if (ckpt.restore)
			rows <= ckpt.restored_map; // Mispredict drops bus and dispatch
		else
			rows <= next_rows;
	end

endmodule

`default_nettype wire

// ==== logic/free_list.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rename_cfg.svh"

module free_list import rename_pkg::*; (
	input logic clock,
	input logic reset,
	dispatch_if.supplier dispatch,
	checkpoint_if.supplier ckpt,
	input logic [`SS_SIZE-1:0] retire_valid,
	input phys_tag_t [`SS_SIZE-1:0] retire_tag
);

	localparam int IDX_W = $clog2(`NUM_PHYS_REG);

	phys_tag_t queue [`NUM_PHYS_REG];
	free_ptr_t head; // Oldest free tag
	free_ptr_t tail; // Next slot to fill
	free_ptr_t count;
	free_ptr_t next_head;
	free_ptr_t next_tail;
	free_ptr_t push_ptr [`SS_SIZE];

	assign count = tail - head; // Wrap bit tells full from empty

	always_comb begin
		for (int s = 0; s < `SS_SIZE; s++) begin
			dispatch.available[s] = count > free_ptr_t'(s);
		end
	end

	// A slot that takes nothing leaves its tag for the next slot
	always_comb begin
		next_head = head;
		for (int s = 0; s < `SS_SIZE; s++) begin
			dispatch.alloc_tag[s] = queue[next_head[IDX_W-1:0]];
			if (dispatch.take[s])
				next_head = next_head + 1'b1;
		end
	end

	assign ckpt.head_snapshot = next_head;

	always_comb begin
		next_tail = tail;
		for (int s = 0; s < `SS_SIZE; s++) begin
			push_ptr[s] = next_tail;
			if (retire_valid[s])
				next_tail = next_tail + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			head <= '0;
			tail <= free_ptr_t'(`NUM_GEN_REG - 1);
			// Tags above the architectural set start free, except the dummy tag
			for (int i = 0; i < `NUM_GEN_REG - 1; i++) begin
				queue[i] <= phys_tag_t'(`NUM_GEN_REG + i);
			end
		end else begin
			// Retired tags stay free, so only the head rolls back
			head <= ckpt.restore ? ckpt.restored_head : next_head;
			tail <= next_tail;
			for (int s = 0; s < `SS_SIZE; s++) begin
				if (retire_valid[s])
					queue[push_ptr[s][IDX_W-1:0]] <= retire_tag[s];
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/checkpoint_store.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rename_cfg.svh"

module checkpoint_store import rename_pkg::*; (
	input logic clock,
	input logic reset,
	checkpoint_if.store ckpt
);

	map_t snap_map [`NUM_CHECKPOINTS];
	free_ptr_t snap_head [`NUM_CHECKPOINTS];

	// Slots not yet saved hold the power-up state
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int c = 0; c < `NUM_CHECKPOINTS; c++) begin
				snap_map[c] <= reset_map();
				snap_head[c] <= '0;
			end
		end else if (ckpt.save) begin
			snap_map[ckpt.save_id] <= ckpt.map_snapshot;
			snap_head[ckpt.save_id] <= ckpt.head_snapshot;
		end
	end

	// Read port for the one-cycle restore
	assign ckpt.restored_map = snap_map[ckpt.restore_id];
	assign ckpt.restored_head = snap_head[ckpt.restore_id];

endmodule

`default_nettype wire

// ==== logic/rename_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rename_cfg.svh"

module rename_unit import rename_pkg::*; (
	input logic clock,
	input logic reset,
	input logic group_valid,
	input logic [`SS_SIZE-1:0] enable,
	input gen_reg_t [`SS_SIZE-1:0] reg_a,
	input gen_reg_t [`SS_SIZE-1:0] reg_b,
	input gen_reg_t [`SS_SIZE-1:0] reg_dest,
	input logic [`SS_SIZE-1:0] cdb_valid,
	input phys_tag_t [`SS_SIZE-1:0] cdb_tag,
	input logic [`SS_SIZE-1:0] retire_valid,
	input phys_tag_t [`SS_SIZE-1:0] retire_tag,
	input logic branch_save,
	input branch_id_t save_id,
	input logic branch_incorrect,
	input branch_id_t branch_id,
	output logic ready,
	output phys_tag_t [`SS_SIZE-1:0] t1,
	output phys_tag_t [`SS_SIZE-1:0] t2,
	output logic [`SS_SIZE-1:0] t1_ready,
	output logic [`SS_SIZE-1:0] t2_ready,
	output phys_tag_t [`SS_SIZE-1:0] t_old,
	output phys_tag_t [`SS_SIZE-1:0] new_tag
);

	dispatch_if dispatch_bus ();
	checkpoint_if ckpt_bus ();

	logic [$clog2(`SS_SIZE):0] need; // Tags this group asks for
	logic accept;

	// Counted from the raw inputs, so ready never depends on itself
	always_comb begin
		need = '0;
		for (int s = 0; s < `SS_SIZE; s++) begin
			if (group_valid && enable[s] && (reg_dest[s] != '0))
				need = need + 1'b1;
		end
		ready = 1'b1;
		for (int s = 0; s < `SS_SIZE; s++) begin
			if ((s < need) && !dispatch_bus.available[s])
				ready = 1'b0;
		end
	end

	assign accept = group_valid && ready && !branch_incorrect; // Mispredict wins

	assign dispatch_bus.enable = enable & {`SS_SIZE{accept}};
	assign dispatch_bus.reg_a = reg_a;
	assign dispatch_bus.reg_b = reg_b;
	assign dispatch_bus.reg_dest = reg_dest;
	assign new_tag = dispatch_bus.alloc_tag;

	assign ckpt_bus.save = branch_save && accept;
	assign ckpt_bus.save_id = save_id;
	assign ckpt_bus.restore = branch_incorrect;
	assign ckpt_bus.restore_id = branch_id;

	map_table map_table_i (
		.clock(clock),
		.reset(reset),
		.dispatch(dispatch_bus),
		.ckpt(ckpt_bus),
		.cdb_valid(cdb_valid),
		.cdb_tag(cdb_tag),
		.t1(t1),
		.t2(t2),
		.t_old(t_old),
		.t1_ready(t1_ready),
		.t2_ready(t2_ready)
	);

	free_list free_list_i (
		.clock(clock),
		.reset(reset),
		.dispatch(dispatch_bus),
		.ckpt(ckpt_bus),
		.retire_valid(retire_valid),
		.retire_tag(retire_tag)
	);

	checkpoint_store checkpoint_store_i (
		.clock(clock),
		.reset(reset),
		.ckpt(ckpt_bus)
	);

endmodule

`default_nettype wire

// ==== test/rename_unit_assertions.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rename_cfg.svh"

module rename_unit_assertions import rename_pkg::*; (
	input logic clock,
	input logic reset,
	input logic group_valid,
	input logic [`SS_SIZE-1:0] enable,
	input gen_reg_t [`SS_SIZE-1:0] reg_dest,
	input logic branch_incorrect,
	input logic ready,
	input phys_tag_t [`SS_SIZE-1:0] new_tag
);

	logic accept;
	logic [`SS_SIZE-1:0] takes; // Slots that pull a tag this cycle

	assign accept = group_valid && ready && !branch_incorrect;

	always_comb begin
		for (int s = 0; s < `SS_SIZE; s++) begin
			takes[s] = accept && enable[s] && (reg_dest[s] != '0);
		end
	end

	ready_known: assert property (@(posedge clock) disable iff (reset) !$isunknown(ready))
		else $error("ready is unknown after reset");

	// The dummy tag belongs to register 0 only
	for (genvar s = 0; s < `SS_SIZE; s++) begin : g_slot
		no_dummy: assert property (@(posedge clock) disable iff (reset)
			takes[s] |-> (new_tag[s] != phys_tag_t'(`DUMMY_TAG)))
			else $error("slot %0d was given the dummy tag", s);
	end

	distinct_tags: assert property (@(posedge clock) disable iff (reset)
		(&takes) |-> (new_tag[0] != new_tag[1]))
		else $error("both slots of one group were given tag %0d", new_tag[0]);

endmodule

bind rename_unit rename_unit_assertions rename_unit_assertions_i (
	.clock(clock),
	.reset(reset),
	.group_valid(group_valid),
	.enable(enable),
	.reg_dest(reg_dest),
	.branch_incorrect(branch_incorrect),
	.ready(ready),
	.new_tag(new_tag)
);

`default_nettype wire

// ==== test/rename_unit_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rename_cfg.svh"

module rename_unit_tb import rename_pkg::*; ();

	typedef struct {
		logic group_valid;
		logic [`SS_SIZE-1:0] enable;
		gen_reg_t [`SS_SIZE-1:0] reg_a;
		gen_reg_t [`SS_SIZE-1:0] reg_b;
		gen_reg_t [`SS_SIZE-1:0] reg_dest;
		logic [`SS_SIZE-1:0] cdb_valid;
		phys_tag_t [`SS_SIZE-1:0] cdb_tag;
		logic [`SS_SIZE-1:0] retire_valid;
		phys_tag_t [`SS_SIZE-1:0] retire_tag;
		logic branch_save;
		branch_id_t save_id;
		logic branch_incorrect;
		branch_id_t branch_id;
		logic exp_ready;
		logic check_src; // Source tags and ready bits of both slots
		phys_tag_t [`SS_SIZE-1:0] exp_t1;
		phys_tag_t [`SS_SIZE-1:0] exp_t2;
		logic [`SS_SIZE-1:0] exp_t1_ready;
		logic [`SS_SIZE-1:0] exp_t2_ready;
		logic check_old;
		phys_tag_t [`SS_SIZE-1:0] exp_old;
		logic [`SS_SIZE-1:0] check_new; // Per slot
		phys_tag_t [`SS_SIZE-1:0] exp_new;
	} row_t;

	logic clock;
	logic reset;
	logic group_valid;
	logic [`SS_SIZE-1:0] enable;
	gen_reg_t [`SS_SIZE-1:0] reg_a;
	gen_reg_t [`SS_SIZE-1:0] reg_b;
	gen_reg_t [`SS_SIZE-1:0] reg_dest;
	logic [`SS_SIZE-1:0] cdb_valid;
	phys_tag_t [`SS_SIZE-1:0] cdb_tag;
	logic [`SS_SIZE-1:0] retire_valid;
	phys_tag_t [`SS_SIZE-1:0] retire_tag;
	logic branch_save;
	branch_id_t save_id;
	logic branch_incorrect;
	branch_id_t branch_id;
	logic ready;
	phys_tag_t [`SS_SIZE-1:0] t1;
	phys_tag_t [`SS_SIZE-1:0] t2;
	logic [`SS_SIZE-1:0] t1_ready;
	logic [`SS_SIZE-1:0] t2_ready;
	phys_tag_t [`SS_SIZE-1:0] t_old;
	phys_tag_t [`SS_SIZE-1:0] new_tag;

	row_t stim_rows[$];
	row_t next_row;
	int limit;
	int cycles;

	rename_unit rename_unit_i (.*);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	function automatic row_t idle_row();
		row_t r;
		r = '{default: '0};
		r.exp_ready = 1'b1;
		return r;
	endfunction

	task automatic set_group(input logic valid, input logic [`SS_SIZE-1:0] en,
		input gen_reg_t a0, b0, d0, a1, b1, d1);
		next_row.group_valid = valid;
		next_row.enable = en;
		next_row.reg_a = {a1, a0};
		next_row.reg_b = {b1, b0};
		next_row.reg_dest = {d1, d0};
	endtask

	task automatic expect_sources(input phys_tag_t a0, input logic a0_rdy,
		input phys_tag_t b0, input logic b0_rdy, input phys_tag_t a1, input logic a1_rdy,
		input phys_tag_t b1, input logic b1_rdy);
		next_row.check_src = 1'b1;
		next_row.exp_t1 = {a1, a0};
		next_row.exp_t1_ready = {a1_rdy, a0_rdy};
		next_row.exp_t2 = {b1, b0};
		next_row.exp_t2_ready = {b1_rdy, b0_rdy};
	endtask

	task automatic expect_old(input phys_tag_t old0, old1);
		next_row.check_old = 1'b1;
		next_row.exp_old = {old1, old0};
	endtask

	task automatic expect_new(input logic [`SS_SIZE-1:0] mask, input phys_tag_t new0, new1);
		next_row.check_new = mask;
		next_row.exp_new = {new1, new0};
	endtask

	task automatic push_row();
		stim_rows.push_back(next_row);
		next_row = idle_row();
	endtask

	// Expected values follow from the reset map (reg i on tag i) and a free list of 32..62
	task automatic build_rows();
		next_row = idle_row();
		set_group(1'b1, 2'b11, 5, 0, 1, 7, 9, 2); // First allocations after reset
		expect_sources(5, 1, 63, 1, 7, 1, 9, 1);
		expect_old(1, 2);
		expect_new(2'b11, 32, 33);
		push_row();
		set_group(1'b1, 2'b11, 1, 2, 3, 3, 3, 3); // Same destination in both slots
		expect_sources(32, 0, 33, 0, 34, 0, 34, 0);
		expect_old(3, 34);
		expect_new(2'b11, 34, 35);
		push_row();
		set_group(1'b1, 2'b11, 1, 3, 4, 2, 4, 5); // Wakeup in the same cycle as the read
		next_row.cdb_valid = 2'b11;
		next_row.cdb_tag = {phys_tag_t'(35), phys_tag_t'(32)};
		expect_sources(32, 1, 35, 1, 33, 0, 36, 0);
		expect_old(4, 5);
		expect_new(2'b11, 36, 37);
		push_row();
		set_group(1'b0, 2'b00, 1, 3, 0, 4, 0, 0); // Ready bits stuck
		expect_sources(32, 1, 35, 1, 36, 0, 63, 1);
		expect_old(63, 63);
		push_row();
		set_group(1'b1, 2'b11, 6, 1, 6, 6, 7, 7);
		next_row.branch_save = 1'b1;
		next_row.save_id = 2;
		expect_sources(6, 1, 32, 1, 38, 0, 7, 1);
		expect_old(6, 7);
		expect_new(2'b11, 38, 39);
		push_row();
		set_group(1'b1, 2'b11, 6, 7, 6, 1, 6, 1); // Wrong path
		expect_sources(38, 0, 39, 0, 32, 1, 40, 0);
		expect_old(38, 32);
		expect_new(2'b11, 40, 41);
		push_row();
		// Mispredict, with a dispatch and a wakeup that must be dropped
		set_group(1'b1, 2'b01, 0, 0, 9, 0, 0, 0);
		next_row.branch_incorrect = 1'b1;
		next_row.branch_id = 2;
		next_row.cdb_valid = 2'b01;
		next_row.cdb_tag = {phys_tag_t'(0), phys_tag_t'(38)};
		push_row();
		set_group(1'b1, 2'b11, 6, 1, 9, 7, 9, 2); // Tags 40 and 41 come back
		expect_sources(38, 0, 32, 1, 39, 0, 40, 0);
		expect_old(9, 33);
		expect_new(2'b11, 40, 41);
		push_row();
		set_group(1'b1, 2'b11, 0, 8, 0, 0, 0, 8); // Register 0 destination
		expect_sources(63, 1, 8, 1, 63, 1, 63, 1);
		expect_old(63, 8);
		expect_new(2'b10, 0, 42);
		push_row();
		set_group(1'b1, 2'b11, 10, 0, 10, 10, 0, 11);
		expect_sources(10, 1, 63, 1, 43, 0, 63, 1);
		expect_old(10, 11);
		expect_new(2'b11, 43, 44);
		push_row();
		for (int k = 0; k < 9; k++) begin
			set_group(1'b1, 2'b11, 0, 0, 11, 0, 0, 12);
			expect_new(2'b11, phys_tag_t'(45 + 2 * k), phys_tag_t'(46 + 2 * k));
			push_row();
		end
		set_group(1'b1, 2'b11, 13, 11, 13, 13, 12, 14); // Free list empty
		next_row.exp_ready = 1'b0;
		expect_old(13, 14);
		push_row();
		set_group(1'b1, 2'b11, 13, 11, 13, 13, 12, 14);
		next_row.exp_ready = 1'b0;
		next_row.retire_valid = 2'b11;
		next_row.retire_tag = {phys_tag_t'(1), phys_tag_t'(34)};
		expect_old(13, 14);
		push_row();
		set_group(1'b1, 2'b11, 13, 11, 13, 13, 12, 14); // Retired tags in retire order
		expect_sources(13, 1, 61, 0, 34, 0, 62, 0);
		expect_old(13, 14);
		expect_new(2'b11, 34, 1);
		push_row();
		set_group(1'b0, 2'b00, 13, 14, 0, 0, 0, 0);
		expect_sources(34, 0, 1, 0, 63, 1, 63, 1);
		expect_old(63, 63);
		push_row();
	endtask

	task automatic apply_inputs(input row_t r);
		group_valid = r.group_valid;
		enable = r.enable;
		reg_a = r.reg_a;
		reg_b = r.reg_b;
		reg_dest = r.reg_dest;
		cdb_valid = r.cdb_valid;
		cdb_tag = r.cdb_tag;
		retire_valid = r.retire_valid;
		retire_tag = r.retire_tag;
		branch_save = r.branch_save;
		save_id = r.save_id;
		branch_incorrect = r.branch_incorrect;
		branch_id = r.branch_id;
	endtask

	task automatic check_tag(input string field, input phys_tag_t got, input phys_tag_t want);
		assert (got === want) else begin
			$display("Error at %0t ns: %s is %0d, expected %0d", $time, field, got, want);
			$display("Checks failed");
			$fatal(1);
		end
	endtask

	task automatic check_bit(input string field, input logic got, input logic want);
		assert (got === want) else begin
			$display("Error at %0t ns: %s is %b, expected %b", $time, field, got, want);
			$display("Checks failed");
			$fatal(1);
		end
	endtask

	task automatic check_outputs(input row_t r, input int index);
		check_bit($sformatf("row %0d ready", index), ready, r.exp_ready);
		for (int s = 0; s < `SS_SIZE; s++) begin
			if (r.check_src) begin
				check_tag($sformatf("row %0d t1[%0d]", index, s), t1[s], r.exp_t1[s]);
				check_bit($sformatf("row %0d t1_ready[%0d]", index, s), t1_ready[s],
					r.exp_t1_ready[s]);
				check_tag($sformatf("row %0d t2[%0d]", index, s), t2[s], r.exp_t2[s]);
				check_bit($sformatf("row %0d t2_ready[%0d]", index, s), t2_ready[s],
					r.exp_t2_ready[s]);
			end
			if (r.check_old)
				check_tag($sformatf("row %0d t_old[%0d]", index, s), t_old[s], r.exp_old[s]);
			if (r.check_new[s])
				check_tag($sformatf("row %0d new_tag[%0d]", index, s), new_tag[s], r.exp_new[s]);
		end
	endtask

	initial begin
		apply_inputs(idle_row());
		reset = 1'b1;
		build_rows();
		limit = stim_rows.size() + 50;
		repeat (10) @(posedge clock);
		#2;
		reset = 1'b0;
		// One row per cycle, sampled just before the next edge
		foreach (stim_rows[i]) begin
			apply_inputs(stim_rows[i]);
			#16;
			check_outputs(stim_rows[i], i);
			@(posedge clock);
			#2;
		end
		$display("All checks passed");
		$finish;
	end

	initial begin
		cycles = 0;
		wait (limit > 0 && !reset);
		while (cycles < limit) begin
			@(posedge clock);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d cycles", limit);
		$display("Checks failed");
		$fatal(1);
	end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+include
logic/rename_pkg.sv
logic/rename_if.sv
logic/tag_cam.sv
logic/map_table.sv
logic/free_list.sv
logic/checkpoint_store.sv
logic/rename_unit.sv
test/rename_unit_assertions.sv
test/rename_unit_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the rename stage testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module rename_unit_tb -f sim.f
./obj_dir/Vrename_unit_tb
